//--- verilog/psgPkg.sv
`default_nettype none

package psgPkg;

	// ==========================================================================
	// subsystem sizes
	// ==========================================================================

	// wave-table channels sharing the RAM read port
	localparam int numChannels = 8;
	localparam int chanIdxW = 3;

	// wave-table RAM holds 1024 signed samples
	localparam int ramAddrW = 10;
	localparam int sampleW = 8;

	// upper eight phase bits form the sample index
	localparam int phaseW = 16;

	localparam int volW = 4;

	// eight channels of 8-bit sample times 4-bit volume
	localparam int mixW = 15;

	// ==========================================================================
	// encodings
	// ==========================================================================

	// channel register select on the host write port
	typedef enum logic [1:0] {
		regFreq = 2'd0,
		regBase = 2'd1,
		regLen  = 2'd2,
		regVol  = 2'd3
	} regSel_t;

	// per-channel fetch state
	typedef enum logic [1:0] {
		chIdle = 2'd0,
		chReq  = 2'd1,
		chHold = 2'd2
	} chanState_t;

endpackage

`default_nettype wire

//--- verilog/psgBusArb.sv
`timescale 1ns/1ps
`default_nettype none

module psgBusArb (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              ce,
	input  logic                              busAck,
	input  logic [psgPkg::numChannels-1:0]    req,
	output logic [psgPkg::numChannels-1:0]    sel,
	output logic [psgPkg::chanIdxW-1:0]       seln
);
	import psgPkg::*;

	logic [chanIdxW-1:0]    winner;
	logic [numChannels-1:0] grant;

	// ==========================================================================
	// fixed priority, channel 0 highest
	// ==========================================================================

	// scan from the top so the lowest active request is the last one kept
	always_comb begin
		winner = '0;
		grant = '0;
		for (int i = numChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				winner = chanIdxW'(i);
				grant = '0;
				grant[i] = 1'b1;
			end
		end
	end

	// ==========================================================================
	// owner register
	// ==========================================================================

	// owner changes only on a tick with the bus free
	// no requests at all keeps the last owner
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (ce && busAck && (|req)) begin
			sel <= grant;
			seln <= winner;
		end
	end

endmodule

`default_nettype wire

//--- verilog/psgWaveRam.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveRam (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              ramWr,
	input  logic [psgPkg::ramAddrW-1:0]       ramAddr,
	input  logic [psgPkg::sampleW-1:0]        ramData,
	input  logic                              rdReq,
	input  logic [psgPkg::ramAddrW-1:0]       rdAddr,
	output logic                              busAck,
	output logic [psgPkg::sampleW-1:0]        rdData
);
	import psgPkg::*;

	logic [sampleW-1:0]  mem [1 << ramAddrW];
	logic [ramAddrW-1:0] addrQ;
	logic                pending;

	// ==========================================================================
	// host write port
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (ramWr) begin
			mem[ramAddr] <= ramData;
		end
	end

	// ==========================================================================
	// read sequence
	// ==========================================================================

	// first cycle of a request latches the address with busAck low,
	// second cycle presents the data with busAck high
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (pending) begin
			pending <= 1'b0;
		end else if (rdReq) begin
			pending <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rdReq && !pending) begin
			addrQ <= rdAddr;
		end
	end

	// idle bus, or data valid this cycle
	assign busAck = !rdReq || pending;
	assign rdData = mem[addrQ];

endmodule

`default_nettype wire

//--- verilog/psgWaveChannel.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveChannel (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              ce,
	input  logic                              regWr,
	input  psgPkg::regSel_t                   regSel,
	input  logic [15:0]                       regData,
	input  logic                              granted,
	input  logic                              busAck,
	input  logic [psgPkg::sampleW-1:0]        rdData,
	output logic                              fetchReq,
	output logic [psgPkg::ramAddrW-1:0]       fetchAddr,
	output logic signed [psgPkg::sampleW-1:0] sample,
	output logic [psgPkg::volW-1:0]           vol,
	output logic                              enable
);
	import psgPkg::*;

	chanState_t          state;
	logic [phaseW-1:0]   freq;
	logic [ramAddrW-1:0] base;
	logic [7:0]          lenMask;
	logic [phaseW-1:0]   phase;
	logic [phaseW-1:0]   nextPhase;
	logic [7:0]          idx;
	logic [7:0]          nextIdx;
	logic                advance;
	logic                capture;

	// ==========================================================================
	// host registers
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= '0;
			base <= '0;
			lenMask <= '0;
			vol <= '0;
			enable <= 1'b0;
		end else if (regWr) begin
			case (regSel)
				regFreq: freq <= regData;
				regBase: base <= regData[ramAddrW-1:0];
				regLen:  lenMask <= regData[7:0];
				regVol: begin
					vol <= regData[volW-1:0];
					// enable sits just above the volume field
					enable <= regData[4];
				end
				default: ;
			endcase
		end
	end

	// ==========================================================================
	// phase accumulator
	// ==========================================================================

	assign nextPhase = phase + freq;
	assign idx = phase[phaseW-1 -: 8];
	assign nextIdx = nextPhase[phaseW-1 -: 8];

	// a new sample is due whenever the index moves
	assign advance = ce && enable && (nextIdx != idx);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (ce && enable) begin
			phase <= nextPhase;
		end
	end

	// ==========================================================================
	// fetch FSM
	// ==========================================================================

	// address follows the live phase, so a late grant reads the newest index
	assign fetchAddr = base + ramAddrW'(idx & lenMask);
	assign fetchReq = (state == chReq);
	assign capture = granted && busAck && (state == chReq);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= chIdle;
			sample <= '0;
		end else begin
			if (capture) begin
				sample <= rdData;
			end
			case (state)
				chIdle, chHold: begin
					if (advance) begin
						state <= chReq;
					end
				end
				chReq: begin
					// index moved again during the capture, so fetch once more
					if (capture && !advance) begin
						state <= chHold;
					end
				end
				default: state <= chIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/psgMixer.sv
`timescale 1ns/1ps
`default_nettype none

module psgMixer (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          ce,
	input  logic [psgPkg::numChannels*psgPkg::sampleW-1:0] samples,
	input  logic [psgPkg::numChannels*psgPkg::volW-1:0]    vols,
	input  logic [psgPkg::numChannels-1:0]                 enables,
	output logic signed [psgPkg::mixW-1:0]                 mixOut,
	output logic                                           mixValid
);
	import psgPkg::*;

	// signed sample times unsigned volume, one guard bit for the volume
	typedef logic signed [sampleW+volW:0] prod_t;

	logic signed [sampleW-1:0] s;
	logic [volW-1:0]           v;
	prod_t                     prod;
	logic signed [mixW-1:0]    mixSum;

	// ==========================================================================
	// multiply-accumulate
	// ==========================================================================

	always_comb begin
		mixSum = '0;
		s = '0;
		v = '0;
		prod = '0;
		for (int i = 0; i < numChannels; i++) begin
			s = samples[i*sampleW +: sampleW];
			v = vols[i*volW +: volW];
			prod = prod_t'(s) * prod_t'({1'b0, v});
			// disabled channels drop out of the sum
			if (enables[i]) begin
				mixSum = mixSum + mixW'(prod);
			end
		end
	end

	// ==========================================================================
	// output register
	// ==========================================================================

	always_ff @(posedge clk) begin
		if (ce) begin
			mixOut <= mixSum;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mixValid <= 1'b0;
		end else begin
			mixValid <= ce;
		end
	end

endmodule

`default_nettype wire

//--- verilog/psgWaveTop.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveTop (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              ce,
	input  logic                              regWr,
	input  logic [psgPkg::chanIdxW-1:0]       regChan,
	input  psgPkg::regSel_t                   regSel,
	input  logic [15:0]                       regData,
	input  logic                              ramWr,
	input  logic [psgPkg::ramAddrW-1:0]       ramAddr,
	input  logic [psgPkg::sampleW-1:0]        ramData,
	output logic signed [psgPkg::mixW-1:0]    mixOut,
	output logic                              mixValid,
	output logic                              fetchDone,
	output logic [psgPkg::chanIdxW-1:0]       fetchChan
);
	import psgPkg::*;

	logic [numChannels-1:0]         chanWr;
	logic [numChannels-1:0]         fetchReq;
	logic [ramAddrW-1:0]            fetchAddr [numChannels];
	logic [numChannels-1:0]         sel;
	logic [chanIdxW-1:0]            seln;
	logic [numChannels*sampleW-1:0] samples;
	logic [numChannels*volW-1:0]    vols;
	logic [numChannels-1:0]         enables;
	logic                           ownerReq;
	logic                           busAck;
	logic [sampleW-1:0]             rdData;

	// ==========================================================================
	// channels
	// ==========================================================================

	for (genvar i = 0; i < numChannels; i++) begin : genChan
		assign chanWr[i] = regWr && (regChan == chanIdxW'(i));

		psgWaveChannel chan (
			.clk       (clk),
			.rst       (rst),
			.ce        (ce),
			.regWr     (chanWr[i]),
			.regSel    (regSel),
			.regData   (regData),
			.granted   (sel[i]),
			.busAck    (busAck),
			.rdData    (rdData),
			.fetchReq  (fetchReq[i]),
			.fetchAddr (fetchAddr[i]),
			.sample    (samples[i*sampleW +: sampleW]),
			.vol       (vols[i*volW +: volW]),
			.enable    (enables[i])
		);
	end

	// ==========================================================================
	// shared read port
	// ==========================================================================

	psgBusArb arb (
		.clk    (clk),
		.rst    (rst),
		.ce     (ce),
		.busAck (busAck),
		.req    (fetchReq),
		.sel    (sel),
		.seln   (seln)
	);

	// only a granted owner drives a read
	assign ownerReq = fetchReq[seln] && sel[seln];

	psgWaveRam ram (
		.clk     (clk),
		.rst     (rst),
		.ramWr   (ramWr),
		.ramAddr (ramAddr),
		.ramData (ramData),
		.rdReq   (ownerReq),
		.rdAddr  (fetchAddr[seln]),
		.busAck  (busAck),
		.rdData  (rdData)
	);

	// the owner captures in the cycle its request sees busAck
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchDone <= 1'b0;
		end else begin
			fetchDone <= ownerReq && busAck;
		end
	end

	always_ff @(posedge clk) begin
		fetchChan <= seln;
	end

	psgMixer mixer (
		.clk      (clk),
		.rst      (rst),
		.ce       (ce),
		.samples  (samples),
		.vols     (vols),
		.enables  (enables),
		.mixOut   (mixOut),
		.mixValid (mixValid)
	);

endmodule

`default_nettype wire

//--- dv/psgWaveTb_chk.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveTbChk (
	input logic                           clk,
	input logic                           rst,
	input logic                           busAck,
	input logic [psgPkg::numChannels-1:0] sel,
	input logic [psgPkg::chanIdxW-1:0]    seln
);
	import psgPkg::*;

	// at most one channel owns the read port
	selOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
		else $error("sel has more than one bit set");

	// a busy bus keeps its owner
	ownerHold: assert property (@(posedge clk) disable iff (rst)
		!busAck |=> ($stable(sel) && $stable(seln)))
		else $error("owner changed while busAck was low");

	// the index names the selected channel
	selnMatch: assert property (@(posedge clk) disable iff (rst)
		(|sel) |-> (sel == (numChannels'(1) << seln)))
		else $error("seln does not match sel");

endmodule

bind psgBusArb psgWaveTbChk chk (
	.clk    (clk),
	.rst    (rst),
	.busAck (busAck),
	.sel    (sel),
	.seln   (seln)
);

`default_nettype wire

//--- dv/psgWaveTb.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveTb;
	import psgPkg::*;

	logic                   clk;
	logic                   rst;
	logic                   ce;
	logic                   regWr;
	logic [chanIdxW-1:0]    regChan;
	regSel_t                regSel;
	logic [15:0]            regData;
	logic                   ramWr;
	logic [ramAddrW-1:0]    ramAddr;
	logic [sampleW-1:0]     ramData;
	logic signed [mixW-1:0] mixOut;
	logic                   mixValid;
	logic                   fetchDone;
	logic [chanIdxW-1:0]    fetchChan;

	logic [chanIdxW-1:0] fetchQ [$];
	int fetchCount = 0;
	int mixErrors = 0;
	int chanErrors = 0;
	int countErrors = 0;
	int otherErrors = 0;

	psgWaveTop dut_i (
		.clk       (clk),
		.rst       (rst),
		.ce        (ce),
		.regWr     (regWr),
		.regChan   (regChan),
		.regSel    (regSel),
		.regData   (regData),
		.ramWr     (ramWr),
		.ramAddr   (ramAddr),
		.ramData   (ramData),
		.mixOut    (mixOut),
		.mixValid  (mixValid),
		.fetchDone (fetchDone),
		.fetchChan (fetchChan)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// fetch monitor samples mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (!rst && fetchDone) begin
			fetchQ.push_back(fetchChan);
			fetchCount++;
		end
	end

	// ==========================================================================
	// compare tasks
	// ==========================================================================

	task automatic checkMix(input logic signed [mixW-1:0] got,
			input logic signed [mixW-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: mix %0d, expected %0d",
				$time, got, exp);
			mixErrors++;
		end
	endtask

	task automatic checkFetchChan(input logic [chanIdxW-1:0] got,
			input logic [chanIdxW-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: fetch from channel %0d, expected %0d",
				$time, got, exp);
			chanErrors++;
		end
	endtask

	task automatic checkFetchCount(input int got, input int exp);
		if (got != exp) begin
			$display("CHECK FAILED at %0t: %0d fetches, expected %0d",
				$time, got, exp);
			countErrors++;
		end
	endtask

	// ==========================================================================
	// stimulus operations
	// ==========================================================================

	task automatic writeRam(input int a, input int d);
		@(posedge clk);
		ramWr <= 1'b1;
		ramAddr <= ramAddrW'(a);
		ramData <= sampleW'(d);
		@(posedge clk);
		ramWr <= 1'b0;
	endtask

	task automatic writeReg(input int c, input int s, input int d);
		@(posedge clk);
		regWr <= 1'b1;
		regChan <= chanIdxW'(c);
		regSel <= regSel_t'(2'(s));
		regData <= 16'(d);
		@(posedge clk);
		regWr <= 1'b0;
	endtask

	// ce high for n edges, then a few idle cycles for the owner to finish
	task automatic runCe(input int n);
		// fetch order lines refer to the run just started
		fetchQ.delete();
		@(posedge clk);
		ce <= 1'b1;
		repeat (n) @(posedge clk);
		ce <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic tickAndMix(input int exp);
		int t;
		@(posedge clk);
		ce <= 1'b1;
		@(posedge clk);
		ce <= 1'b0;
		t = 0;
		// valid pulse is read mid-cycle
		@(negedge clk);
		while (!mixValid && t < 20) begin
			@(negedge clk);
			t++;
		end
		if (mixValid) begin
			checkMix(mixOut, mixW'(exp));
		end else begin
			$display("timeout at %0t: mixValid never rose after a tick", $time);
			otherErrors++;
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic expectFetch(input int exp);
		int t;
		logic [chanIdxW-1:0] got;
		t = 0;
		while (fetchQ.size() == 0 && t < 200) begin
			@(posedge clk);
			t++;
		end
		if (fetchQ.size() == 0) begin
			$display("timeout at %0t: no fetch arrived, channel %0d was due",
				$time, exp);
			otherErrors++;
		end else begin
			got = fetchQ.pop_front();
			checkFetchChan(got, chanIdxW'(exp));
		end
	endtask

	task automatic holdCeLow(input int n);
		repeat (n) begin
			@(negedge clk);
			if (mixValid) begin
				$display("mixValid pulsed at %0t with ce held low", $time);
				otherErrors++;
			end
		end
	endtask

	// ==========================================================================
	// main sequence
	// ==========================================================================

	initial begin
		int fd;
		int code;
		string line;
		byte op;
		int a;
		int b;
		int d;
		rst = 1'b1;
		ce = 1'b0;
		regWr = 1'b0;
		regChan = '0;
		regSel = regFreq;
		regData = '0;
		ramWr = 1'b0;
		ramAddr = '0;
		ramData = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		fd = $fopen("dv/psgWaveInput.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file dv/psgWaveInput.txt");
			otherErrors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				// skip blank and comment lines
				if (code > 0 && line.len() > 1 && line[0] != "#") begin
					op = line[0];
					case (op)
						"R": begin
							code = $sscanf(line, "%c %h %h", op, a, d);
							writeRam(a, d);
						end
						"W": begin
							code = $sscanf(line, "%c %d %d %h", op, a, b, d);
							writeReg(a, b, d);
						end
						"C": begin
							code = $sscanf(line, "%c %d", op, a);
							runCe(a);
						end
						"M": begin
							code = $sscanf(line, "%c %d", op, d);
							tickAndMix(d);
						end
						"F": begin
							code = $sscanf(line, "%c %d", op, a);
							expectFetch(a);
						end
						"N": begin
							code = $sscanf(line, "%c %d", op, a);
							checkFetchCount(fetchCount, a);
						end
						"H": begin
							code = $sscanf(line, "%c %d", op, a);
							holdCeLow(a);
						end
						default: begin
							$display("unknown operation in the stimulus file: %s", line);
							otherErrors++;
						end
					endcase
				end
			end
			$fclose(fd);
		end
		$display("errors: mix %0d, fetch channel %0d, fetch count %0d, other %0d",
			mixErrors, chanErrors, countErrors, otherErrors);
		if (mixErrors + chanErrors + countErrors + otherErrors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/psgWaveInput.txt
# R addr data (hex) | W chan reg data (reg 0 freq, 1 base, 2 len, 3 vol; data hex)
# C ce-high cycles | M expected mix (signed dec) | F expected channel | N fetch count | H ce-low cycles
M 0
N 0
R 000 0c
R 001 f0
R 002 19
R 003 07
R 100 9c
R 200 28
W 0 0 0100
W 0 2 0003
W 0 3 0012
C 2
M 50
M 14
M 24
M -32
W 0 3 0002
W 1 0 0010
W 1 1 0100
W 1 3 0019
W 2 0 0010
W 2 1 0200
W 2 3 0012
W 3 0 0010
W 3 3 0013
C 24
F 1
F 2
F 3
M -784
C 7
F 3
H 20
N 9

//--- all.f
verilog/psgPkg.sv
verilog/psgBusArb.sv
verilog/psgWaveRam.sv
verilog/psgWaveChannel.sv
verilog/psgMixer.sv
verilog/psgWaveTop.sv
dv/psgWaveTb_chk.sv
dv/psgWaveTb.sv

//--- run.sh
#!/bin/sh
# build and run the wave-table testbench, then scan the log for a failure
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module psgWaveTb -f all.f -o psgWaveSim \
	&& ./obj_dir/psgWaveSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
